/* verilog/cpuPkg.sv */
package cpuPkg;

	localparam int opcodeWidth = 5;
	localparam int regFieldWidth = 4;

	// instruction opcodes, bits 31 to 27 of the instruction word.
	typedef enum logic [opcodeWidth-1:0] {
		opLd = 5'd0,
		opLdi = 5'd1,
		opSt = 5'd2,
		opAdd = 5'd3,
		opSub = 5'd4,
		opAnd = 5'd5,
		opOr = 5'd6,
		opShl = 5'd7,
		opShr = 5'd8,
		opAddi = 5'd9,
		opNop = 5'd26,
		opHalt = 5'd27
	} opcodeT;

	typedef enum logic [3:0] {
		stepIdle,
		stepT0,
		stepT1,
		stepT2,
		stepT3,
		stepT4,
		stepT5,
		stepT6,
		stepT7,
		stepStopped
	} stepT;

	typedef enum logic [2:0] {
		aluPass,
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluShl,
		aluShr,
		aluInc4
	} aluOpT;

	typedef enum logic [2:0] {
		srcReg,
		srcPc,
		srcMdr,
		srcZLow,
		srcConst
	} busSrcT;

endpackage

/* verilog/selectEncode.sv */
`timescale 1ns/10ps

module selectEncode (
	input logic [31:0] ir,
	input logic gra,
	input logic grb,
	input logic grc,
	input logic rin,
	input logic rout,
	input logic baOut,
	output logic [15:0] regIn,
	output logic [15:0] regOut
);

	import cpuPkg::*;

	logic [regFieldWidth-1:0] field;
	logic [15:0] decoded;
	logic anySelect;

	// ra wins over rb, rb over rc.
	always_comb begin
		field = '0;
		if (gra) begin
			field = ir[26 -: regFieldWidth];
		end
		else if (grb) begin
			field = ir[22 -: regFieldWidth];
		end
		else if (grc) begin
			field = ir[18 -: regFieldWidth];
		end
	end

	assign anySelect = gra | grb | grc;

	// 4 to 16 one-hot decode.
	assign decoded = anySelect ? (16'b1 << field) : 16'b0;

	assign regIn = rin ? decoded : 16'b0;
	assign regOut = (rout | baOut) ? decoded : 16'b0; // baOut reads like rout, the zero is in the file.

endmodule

/* verilog/registerFile.sv */
`timescale 1ns/10ps

module registerFile #(
	parameter int dataWidth = 32
) (
	input logic clock,
	input logic reset,
	input logic [15:0] regIn,
	input logic [15:0] regOut,
	input logic baOut,
	input logic [dataWidth-1:0] bus,
	output logic [dataWidth-1:0] regData
);

	logic [dataWidth-1:0] regs [16];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end
		else begin
			for (int i = 0; i < 16; i++) begin
				if (regIn[i]) begin
					regs[i] <= bus;
				end
			end
		end
	end

	// regOut is one-hot, so an or of the gated registers is the selected one.
	always_comb begin
		regData = '0;
		for (int i = 1; i < 16; i++) begin
			if (regOut[i]) begin
				regData = regData | regs[i];
			end
		end
		if (regOut[0] && !baOut) begin
			regData = regData | regs[0]; // r0 as a base reads as zero.
		end
	end

endmodule

/* verilog/alu.sv */
`timescale 1ns/10ps

module alu #(
	parameter int dataWidth = 32
) (
	input cpuPkg::aluOpT aluOp,
	input logic [dataWidth-1:0] a,
	input logic [dataWidth-1:0] b,
	output logic [dataWidth-1:0] result
);

	import cpuPkg::*;

	logic [4:0] shiftAmount;

	assign shiftAmount = b[4:0];

	always_comb begin
		case (aluOp)
			aluPass: begin
				result = b;
			end
			aluAdd: begin
				result = a + b;
			end
			aluSub: begin
				result = a - b;
			end
			aluAnd: begin
				result = a & b;
			end
			aluOr: begin
				result = a | b;
			end
			aluShl: begin
				result = a << shiftAmount;
			end
			aluShr: begin
				result = a >> shiftAmount; // logical, zero fill.
			end
			aluInc4: begin
				result = a + dataWidth'(4); // next instruction address.
			end
			default: begin
				result = b;
			end
		endcase
	end

endmodule

/* verilog/busMux.sv */
`timescale 1ns/10ps

module busMux #(
	parameter int dataWidth = 32
) (
	input cpuPkg::busSrcT busSrc,
	input logic [dataWidth-1:0] regData,
	input logic [dataWidth-1:0] pc,
	input logic [dataWidth-1:0] mdr,
	input logic [dataWidth-1:0] zLow,
	input logic [dataWidth-1:0] constant,
	output logic [dataWidth-1:0] bus
);

	import cpuPkg::*;

	always_comb begin
		case (busSrc)
			srcReg: begin
				bus = regData;
			end
			srcPc: begin
				bus = pc;
			end
			srcMdr: begin
				bus = mdr;
			end
			srcZLow: begin
				bus = zLow;
			end
			srcConst: begin
				bus = constant;
			end
			default: begin
				bus = '0;
			end
		endcase
	end

endmodule

/* verilog/mainMemory.sv */
`timescale 1ns/10ps

module mainMemory #(
	parameter int dataWidth = 32,
	parameter int memDepth = 512
) (
	input logic clock,
	input logic write,
	input logic [$clog2(memDepth)-1:0] addr,
	input logic [dataWidth-1:0] writeData,
	output logic [dataWidth-1:0] readData
);

	logic [dataWidth-1:0] mem [memDepth];

	// word addressed; readData holds the old word on a write cycle.
	always_ff @(posedge clock) begin
		if (write) begin
			mem[addr] <= writeData;
		end
		readData <= mem[addr];
	end

endmodule

/* verilog/controlUnit.sv */
`timescale 1ns/10ps

module controlUnit #(
	parameter int dataWidth = 32,
	parameter int memDepth = 512
) (
	input logic clock,
	input logic reset,
	input logic start,
	input logic [dataWidth-1:0] bus,
	input logic [dataWidth-1:0] aluResult,
	input logic [dataWidth-1:0] memReadData,
	input logic loadWrite,
	input logic [$clog2(memDepth)-1:0] loadAddr,
	input logic [dataWidth-1:0] loadData,
	output logic [31:0] ir,
	output logic gra,
	output logic grb,
	output logic grc,
	output logic rin,
	output logic rout,
	output logic baOut,
	output cpuPkg::busSrcT busSrc,
	output logic [dataWidth-1:0] constant,
	output cpuPkg::aluOpT aluOp,
	output logic [dataWidth-1:0] yOut,
	output logic [dataWidth-1:0] zLow,
	output logic [dataWidth-1:0] pc,
	output logic [dataWidth-1:0] mdr,
	output logic memWrite,
	output logic [$clog2(memDepth)-1:0] memAddr,
	output logic [dataWidth-1:0] memWriteData,
	output logic halted
);

	import cpuPkg::*;

	localparam int addrWidth = $clog2(memDepth);

	stepT step;
	stepT nextStep;
	opcodeT opcode;
	aluOpT regAluOp;
	logic [addrWidth-1:0] mar;
	logic pcIn, marIn, mdrRead, mdrLoad, irIn, yIn, zIn, memStrobe;
	logic loadPortActive;
	logic memOp;

	assign opcode = opcodeT'(ir[31 -: opcodeWidth]);
	assign constant = {{(dataWidth-19){ir[18]}}, ir[18:0]}; // C2, sign-extended.
	assign halted = (step == stepStopped);
	assign loadPortActive = (step == stepIdle) || (step == stepStopped);
	assign memOp = (opcode == opLd) || (opcode == opSt);

	always_comb begin
		case (opcode)
			opSub: regAluOp = aluSub;
			opAnd: regAluOp = aluAnd;
			opOr: regAluOp = aluOr;
			opShl: regAluOp = aluShl;
			opShr: regAluOp = aluShr;
			default: regAluOp = aluAdd;
		endcase
	end

	always_comb begin
		{gra, grb, grc, rin, rout, baOut} = 6'b0;
		{pcIn, marIn, mdrRead, mdrLoad, irIn, yIn, zIn, memStrobe} = 8'b0;
		busSrc = srcReg;
		aluOp = aluPass;
		nextStep = step;
		case (step)
			stepIdle: begin
				if (start) begin
					nextStep = stepT0;
				end
			end
			stepT0: begin
				busSrc = srcPc; // fetch read issued straight from the bus.
				marIn = 1'b1;
				yIn = 1'b1;
				nextStep = stepT1;
			end
			stepT1: begin
				aluOp = aluInc4;
				zIn = 1'b1;
				mdrRead = 1'b1;
				nextStep = stepT2;
			end
			stepT2: begin
				busSrc = srcZLow;
				pcIn = 1'b1;
				irIn = 1'b1;
				nextStep = stepT3;
			end
			stepT3: begin
				case (opcode)
					opLd, opLdi, opSt: begin
						grb = 1'b1;
						baOut = 1'b1;
						yIn = 1'b1;
						nextStep = stepT4;
					end
					opAdd, opSub, opAnd, opOr, opShl, opShr, opAddi: begin
						grb = 1'b1;
						rout = 1'b1;
						yIn = 1'b1;
						nextStep = stepT4;
					end
					opHalt: nextStep = stepStopped;
					default: nextStep = stepT0; // nop and unused codes.
				endcase
			end
			stepT4: begin
				zIn = 1'b1;
				nextStep = stepT5;
				case (opcode)
					opLd, opLdi, opSt, opAddi: begin
						busSrc = srcConst;
						aluOp = aluAdd;
					end
					default: begin
						grc = 1'b1;
						rout = 1'b1;
						aluOp = regAluOp;
					end
				endcase
			end
			stepT5: begin
				busSrc = srcZLow;
				if (memOp) begin
					marIn = 1'b1; // effective address.
					nextStep = stepT6;
				end
				else begin
					gra = 1'b1;
					rin = 1'b1;
					nextStep = stepT0;
				end
			end
			stepT6: begin
				nextStep = stepT7;
				if (opcode == opSt) begin
					gra = 1'b1;
					rout = 1'b1;
					mdrLoad = 1'b1;
				end
				else begin
					mdrRead = 1'b1;
				end
			end
			stepT7: begin
				nextStep = stepT0;
				if (opcode == opSt) begin
					memStrobe = 1'b1;
				end
				else begin
					busSrc = srcMdr;
					gra = 1'b1;
					rin = 1'b1;
				end
			end
			default: nextStep = step;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			step <= stepIdle;
			pc <= '0;
			ir <= '0;
		end
		else begin
			step <= nextStep;
			if (pcIn) begin
				pc <= bus;
			end
			if (irIn) begin
				ir <= mdr[31:0];
			end
		end
	end

	always_ff @(posedge clock) begin
		if (marIn) begin
			mar <= bus[addrWidth+1:2]; // byte address to word index.
		end
		if (mdrRead) begin
			mdr <= memReadData;
		end
		else if (mdrLoad) begin
			mdr <= bus;
		end
		if (yIn) begin
			yOut <= bus;
		end
		if (zIn) begin
			zLow <= aluResult;
		end
	end

	// load port owns the memory while the processor is not running.
	always_comb begin
		if (loadPortActive) begin
			memAddr = loadAddr;
			memWrite = loadWrite;
			memWriteData = loadData;
		end
		else begin
			memAddr = marIn ? bus[addrWidth+1:2] : mar;
			memWrite = memStrobe;
			memWriteData = mdr;
		end
	end

endmodule

/* verilog/cpuTop.sv */
`timescale 1ns/10ps

module cpuTop #(
	parameter int dataWidth = 32,
	parameter int memDepth = 512
) (
	input logic clock,
	input logic reset,
	input logic start,
	input logic loadWrite,
	input logic [$clog2(memDepth)-1:0] loadAddr,
	input logic [dataWidth-1:0] loadData,
	output logic [dataWidth-1:0] memData,
	output logic halted
);

	import cpuPkg::*;

	logic [31:0] ir;
	logic gra, grb, grc, rin, rout, baOut;
	logic [15:0] regIn;
	logic [15:0] regOut;
	busSrcT busSrc;
	aluOpT aluOp;
	logic [dataWidth-1:0] constant, yOut, zLow, pc, mdr;
	logic [dataWidth-1:0] bus, regData, aluResult;
	logic memWrite;
	logic [$clog2(memDepth)-1:0] memAddr;
	logic [dataWidth-1:0] memWriteData;

	controlUnit #(
		.dataWidth(dataWidth),
		.memDepth(memDepth)
	) u_controlUnit (
		.clock(clock),
		.reset(reset),
		.start(start),
		.bus(bus),
		.aluResult(aluResult),
		.memReadData(memData), // memory output serves both the CPU and the load port.
		.loadWrite(loadWrite),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.ir(ir),
		.gra(gra),
		.grb(grb),
		.grc(grc),
		.rin(rin),
		.rout(rout),
		.baOut(baOut),
		.busSrc(busSrc),
		.constant(constant),
		.aluOp(aluOp),
		.yOut(yOut),
		.zLow(zLow),
		.pc(pc),
		.mdr(mdr),
		.memWrite(memWrite),
		.memAddr(memAddr),
		.memWriteData(memWriteData),
		.halted(halted)
	);

	selectEncode u_selectEncode (
		.ir(ir),
		.gra(gra),
		.grb(grb),
		.grc(grc),
		.rin(rin),
		.rout(rout),
		.baOut(baOut),
		.regIn(regIn),
		.regOut(regOut)
	);

	registerFile #(.dataWidth(dataWidth)) u_registerFile (
		.clock(clock),
		.reset(reset),
		.regIn(regIn),
		.regOut(regOut),
		.baOut(baOut),
		.bus(bus),
		.regData(regData)
	);

	busMux #(.dataWidth(dataWidth)) u_busMux (
		.busSrc(busSrc),
		.regData(regData),
		.pc(pc),
		.mdr(mdr),
		.zLow(zLow),
		.constant(constant),
		.bus(bus)
	);

	alu #(.dataWidth(dataWidth)) u_alu (
		.aluOp(aluOp),
		.a(yOut),
		.b(bus),
		.result(aluResult)
	);

	mainMemory #(
		.dataWidth(dataWidth),
		.memDepth(memDepth)
	) u_mainMemory (
		.clock(clock),
		.write(memWrite),
		.addr(memAddr),
		.writeData(memWriteData),
		.readData(memData)
	);

endmodule

/* testbench/cpuTb.sv */
`timescale 1ns/10ps

module cpuTb;

	import cpuPkg::*;

	localparam int dataWidth = 32;
	localparam int memDepth = 512;
	localparam int addrWidth = $clog2(memDepth);
	localparam int numRows = 11;
	localparam int windowSize = 16; // words checked around each result address.
	localparam int runLimit = 300; // longest program, regFile, needs about 230 cycles.
	localparam int cyclesPerRow = 200;

	logic clock;
	logic reset;
	logic start;
	logic loadWrite;
	logic [addrWidth-1:0] loadAddr;
	logic [dataWidth-1:0] loadData;
	logic [dataWidth-1:0] memData;
	logic halted;

	logic [31:0] lfsrState;
	int errorCount;
	int checkCount;
	logic [31:0] prog [$];
	logic [31:0] expectWords [windowSize];

	string testName [numRows] = '{"add", "sub", "and", "or", "shl", "shr", "addiNegative",
		"baseZero", "baseReg", "regFile", "nopHalt"};
	opcodeT testOp [numRows] = '{opAdd, opSub, opAnd, opOr, opShl, opShr, opAddi, opLd, opSt,
		opLdi, opNop};
	int testAddr [numRows] = '{100, 120, 140, 160, 180, 200, 220, 240, 260, 280, 320};

	cpuTop #(
		.dataWidth(dataWidth),
		.memDepth(memDepth)
	) u_cpuTop (
		.clock(clock),
		.reset(reset),
		.start(start),
		.loadWrite(loadWrite),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.memData(memData),
		.halted(halted)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#2 clock = ~clock;
		end
	end

	// x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] randomBits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			value = {value[30:0], lfsrState[0]};
		end
		return value;
	endfunction

	function automatic logic [31:0] signExtend(input logic [31:0] v);
		return {{13{v[18]}}, v[18:0]}; // C2 is 19 bits.
	endfunction

	function automatic logic [31:0] byteAddr(input int word);
		return 32'(word * 4);
	endfunction

	function automatic logic [31:0] fillPattern(input int addr);
		return {addr[15:0] ^ 16'hc3a5, ~addr[15:0]};
	endfunction

	function automatic logic [31:0] encodeImm(input opcodeT op, input int ra, input int rb,
		input logic [31:0] c2);
		return {op, ra[regFieldWidth-1:0], rb[regFieldWidth-1:0], c2[18:0]};
	endfunction

	function automatic logic [31:0] encodeReg(input opcodeT op, input int ra, input int rb,
		input int rc);
		return {op, ra[regFieldWidth-1:0], rb[regFieldWidth-1:0], rc[regFieldWidth-1:0], 15'd0};
	endfunction

	function automatic logic [31:0] applyOp(input opcodeT op, input logic [31:0] a,
		input logic [31:0] b);
		case (op)
			opAdd: return a + b;
			opSub: return a - b;
			opAnd: return a & b;
			opOr: return a | b;
			opShl: return a << b[4:0];
			opShr: return a >> b[4:0];
			default: return a;
		endcase
	endfunction

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (actual !== expected) begin
			$display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic writeWord(input int addr, input logic [31:0] data);
		@(posedge clock);
		#1;
		loadWrite = 1'b1;
		loadAddr = addr[addrWidth-1:0];
		loadData = data;
	endtask

	task automatic endLoad();
		@(posedge clock);
		#1;
		loadWrite = 1'b0;
	endtask

	// memData follows loadAddr by one cycle.
	task automatic readWord(input int addr, output logic [31:0] data);
		@(posedge clock);
		#1;
		loadWrite = 1'b0;
		loadAddr = addr[addrWidth-1:0];
		@(posedge clock);
		#1;
		data = memData;
	endtask

	task automatic resetDut();
		@(posedge clock);
		#1;
		reset = 1'b1;
		start = 1'b0;
		loadWrite = 1'b0;
		repeat (2) @(posedge clock);
		#1;
		reset = 1'b0;
	endtask

	task automatic runProgram(input string name);
		int cycles;
		@(posedge clock);
		#1;
		start = 1'b1;
		@(posedge clock);
		#1;
		start = 1'b0;
		cycles = 0;
		while (halted !== 1'b1 && cycles < runLimit) begin
			@(posedge clock);
			#1;
			cycles++;
		end
		if (halted !== 1'b1) begin
			$display("ERROR %s: processor did not halt within %0d cycles", name, runLimit);
			errorCount++;
		end
	endtask

	// builds the program for row r and the words expected in its window.
	task automatic prepareRow(input int r);
		int base;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c2;
		logic [31:0] data;
		base = testAddr[r];
		prog.delete();
		for (int i = 0; i < windowSize; i++) begin
			expectWords[i] = fillPattern(base + i);
		end
		case (testOp[r])
			opAdd, opSub, opAnd, opOr, opShl, opShr: begin
				a = signExtend(randomBits(19));
				if (testOp[r] == opShl || testOp[r] == opShr) begin
					b = randomBits(5);
				end
				else begin
					b = signExtend(randomBits(19));
				end
				prog.push_back(encodeImm(opLdi, 1, 0, a));
				prog.push_back(encodeImm(opLdi, 2, 0, b));
				prog.push_back(encodeReg(testOp[r], 3, 1, 2));
				prog.push_back(encodeImm(opSt, 3, 0, byteAddr(base)));
				expectWords[0] = applyOp(testOp[r], a, b);
			end
			opAddi: begin
				a = signExtend(randomBits(19));
				c2 = signExtend(randomBits(18) | 32'h40000); // always negative.
				prog.push_back(encodeImm(opLdi, 1, 0, a));
				prog.push_back(encodeImm(opAddi, 3, 1, c2));
				prog.push_back(encodeImm(opSt, 3, 0, byteAddr(base)));
				expectWords[0] = a + c2;
			end
			opLd: begin
				data = randomBits(32);
				writeWord(base + windowSize, data);
				prog.push_back(encodeImm(opLdi, 0, 0, randomBits(18) | 32'd1)); // r0 nonzero.
				prog.push_back(encodeImm(opLd, 4, 0, byteAddr(base + windowSize)));
				prog.push_back(encodeImm(opSt, 4, 0, byteAddr(base)));
				expectWords[0] = data;
			end
			opSt: begin
				data = randomBits(32);
				writeWord(base + windowSize, data);
				a = byteAddr(base + 8);
				prog.push_back(encodeImm(opLdi, 5, 0, a));
				prog.push_back(encodeImm(opLd, 6, 5, byteAddr(windowSize - 8)));
				prog.push_back(encodeImm(opSt, 6, 5, -byteAddr(5)));
				expectWords[3] = data;
			end
			opLdi: begin
				for (int i = 0; i < 16; i++) begin
					a = (randomBits(14) << 4) | 32'(i); // low nibble keeps values distinct.
					prog.push_back(encodeImm(opLdi, i, 0, a));
					expectWords[i] = a;
				end
				for (int i = 0; i < 16; i++) begin
					prog.push_back(encodeImm(opSt, i, 0, byteAddr(base + i)));
				end
			end
			opNop: begin
				a = signExtend(randomBits(19));
				prog.push_back(encodeReg(opNop, 0, 0, 0));
				prog.push_back(encodeReg(opNop, 0, 0, 0));
				prog.push_back(encodeImm(opLdi, 7, 0, a));
				prog.push_back(encodeImm(opSt, 7, 0, byteAddr(base + 5)));
				expectWords[5] = a;
			end
			default: begin
			end
		endcase
		prog.push_back(encodeReg(opHalt, 0, 0, 0));
	endtask

	initial begin
		logic [31:0] word;
		reset = 1'b1;
		start = 1'b0;
		loadWrite = 1'b0;
		loadAddr = '0;
		loadData = '0;
		lfsrState = 32'h5a2e7849;
		errorCount = 0;
		checkCount = 0;
		for (int r = 0; r < numRows; r++) begin
			resetDut();
			checkValue($sformatf("%s halted after reset", testName[r]), 32'd0, {31'd0, halted});
			prepareRow(r);
			for (int i = 0; i < windowSize; i++) begin
				writeWord(testAddr[r] + i, fillPattern(testAddr[r] + i));
			end
			for (int i = 0; i < prog.size(); i++) begin
				writeWord(i, prog[i]);
			end
			endLoad();
			runProgram(testName[r]);
			for (int i = 0; i < windowSize; i++) begin
				readWord(testAddr[r] + i, word);
				checkValue($sformatf("%s word %0d", testName[r], testAddr[r] + i),
					expectWords[i], word);
			end
			checkValue($sformatf("%s halted after halt", testName[r]), 32'd1, {31'd0, halted});
		end
		$display("checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("All checks passed");
		end
		else begin
			$display("Checks failed");
		end
		$finish;
	end

	// watchdog sized from the row count.
	initial begin
		repeat (numRows * cyclesPerRow) @(posedge clock);
		$display("TIMEOUT after %0d cycles: the processor never halted", numRows * cyclesPerRow);
		$display("Checks failed");
		$finish;
	end

endmodule

/* tb.f */
verilog/cpuPkg.sv
verilog/selectEncode.sv
verilog/registerFile.sv
verilog/alu.sv
verilog/busMux.sv
verilog/mainMemory.sv
verilog/controlUnit.sv
verilog/cpuTop.sv
testbench/cpuTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= cpuTb
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0
LOG ?= sim.log
PASS_TEXT ?= All checks passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then echo "PASS"; else echo "FAIL"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
